/* Makefile */
VERILATOR ?= verilator
TOP       ?= texture_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it and search $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation did not pass, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/joint_histogram.sv */
`timescale 1ns/1ps

module joint_histogram (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clear_i,
  input  texture_pkg::code_t            code_i,
  input  logic                          code_valid_i,
  input  logic [texture_pkg::BIN_W-1:0] rd_bin_i,
  output logic [texture_pkg::CNT_W-1:0] rd_count_o,
  output logic                          done_o
);
  import texture_pkg::*;

  logic [CNT_W-1:0] cnt_q [NUM_BINS];
  logic [BIN_W-1:0] bin_idx;
  logic             last_seen_q;
  logic             done_q;
  logic [CNT_W-1:0] rd_count_q;

  // ci selects the upper half
  assign bin_idx = code_i.ci ? BIN_W'(NUM_BINS / 2) + BIN_W'(code_i.ni)
                             : BIN_W'(code_i.ni);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < NUM_BINS; k++) begin
        cnt_q[k] <= '0;
      end
      last_seen_q <= 1'b0;
      done_q      <= 1'b0;
    end else if (clear_i) begin
      for (int k = 0; k < NUM_BINS; k++) begin
        cnt_q[k] <= '0;
      end
      last_seen_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      for (int k = 0; k < NUM_BINS; k++) begin
        if (code_valid_i && (bin_idx == BIN_W'(k)) && (cnt_q[k] != '1)) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;   // saturate at max
        end
      end
      last_seen_q <= code_valid_i && code_i.last;
      if (last_seen_q) begin
        done_q <= 1'b1;                  // one cycle after last update
      end
    end
  end

  // ------------------------------
  // registered read port
  always_ff @(posedge clk) begin
    rd_count_q <= (rd_bin_i < BIN_W'(NUM_BINS)) ? cnt_q[rd_bin_i] : '0;
  end

  assign rd_count_o = rd_count_q;
  assign done_o     = done_q;

endmodule

/* rtl/lbp_code.sv */
`timescale 1ns/1ps

module lbp_code (
  input  logic                          clk,
  input  logic                          rst_n,
  input  texture_pkg::window_t          win_i,
  input  logic                          win_valid_i,
  input  logic [texture_pkg::PIX_W-1:0] thresh_i,
  output texture_pkg::code_t            code_o,
  output logic                          code_valid_o
);
  import texture_pkg::*;

  logic [7:0]      nbr_ge;
  logic [NI_W-1:0] ni_sum;
  code_t           code_q;
  logic            code_valid_q;

  // neighbor compare and popcount
  always_comb begin
    ni_sum = '0;
    for (int k = 0; k < 8; k++) begin
      nbr_ge[k] = (win_i.nbr[k] >= win_i.center);
      ni_sum    = ni_sum + NI_W'(nbr_ge[k]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      code_valid_q <= 1'b0;
    end else begin
      code_valid_q <= win_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      code_q.ci   <= (win_i.center >= thresh_i);  // center vs threshold
      code_q.ni   <= ni_sum;
      code_q.last <= win_i.last;
    end
  end

  assign code_o       = code_q;
  assign code_valid_o = code_valid_q;

endmodule

/* rtl/texture_pkg.sv */
package texture_pkg;

  // ------------------------------
  // frame and datapath sizes
  localparam int IMG_COLS = 8;
  localparam int IMG_ROWS = 8;
  localparam int COL_W    = $clog2(IMG_COLS);
  localparam int ROW_W    = $clog2(IMG_ROWS);
  localparam int PIX_W    = 8;
  localparam int NI_W     = 4;           // 0..8 neighbors
  localparam int NUM_BINS = 18;          // 2 ci x 9 ni
  localparam int BIN_W    = 5;
  localparam int CNT_W    = 16;

  // ------------------------------
  // register bus
  localparam int AXI_AW = 8;
  localparam int AXI_DW = 32;

  typedef struct packed {
    logic [PIX_W-1:0]      center;
    logic [7:0][PIX_W-1:0] nbr;          // NW N NE W E SW S SE, index 0 = NW
    logic                  last;         // final window of frame
  } window_t;

  typedef struct packed {
    logic            ci;
    logic [NI_W-1:0] ni;
    logic            last;
  } code_t;

  typedef enum logic [AXI_AW-1:0] {
    ADDR_CTRL     = 8'h00,
    ADDR_THRESH   = 8'h04,
    ADDR_STATUS   = 8'h08,
    ADDR_BIN_BASE = 8'h40                // bin k at base + 4k
  } reg_addr_e;

  typedef enum logic [1:0] {IDLE, WRESP, RWAIT, RRESP} axi_state_e;

endpackage

/* rtl/texture_regs.sv */
`timescale 1ns/1ps

module texture_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [texture_pkg::AXI_AW-1:0]   s_axi_awaddr_i,
  input  logic                             s_axi_awvalid_i,
  output logic                             s_axi_awready_o,
  input  logic [texture_pkg::AXI_DW-1:0]   s_axi_wdata_i,
  input  logic [texture_pkg::AXI_DW/8-1:0] s_axi_wstrb_i,
  input  logic                             s_axi_wvalid_i,
  output logic                             s_axi_wready_o,
  output logic [1:0]                       s_axi_bresp_o,
  output logic                             s_axi_bvalid_o,
  input  logic                             s_axi_bready_i,
  input  logic [texture_pkg::AXI_AW-1:0]   s_axi_araddr_i,
  input  logic                             s_axi_arvalid_i,
  output logic                             s_axi_arready_o,
  output logic [texture_pkg::AXI_DW-1:0]   s_axi_rdata_o,
  output logic [1:0]                       s_axi_rresp_o,
  output logic                             s_axi_rvalid_o,
  input  logic                             s_axi_rready_i,
  output logic [texture_pkg::PIX_W-1:0]    thresh_o,
  output logic                             start_o,
  output logic [texture_pkg::BIN_W-1:0]    rd_bin_o,
  input  logic [texture_pkg::CNT_W-1:0]    rd_count_i,
  input  logic                             done_i
);
  import texture_pkg::*;

  axi_state_e        state_q;
  logic              awready_q, wready_q, bvalid_q, arready_q, rvalid_q;
  logic              start_q;
  logic [PIX_W-1:0]  thresh_q;
  logic [AXI_AW-1:0] wr_word, ar_word, ar_off;
  logic              ar_is_bin, ar_take;
  logic [AXI_AW-1:0] rd_addr_q;
  logic              rd_is_bin_q;
  logic [BIN_W-1:0]  rd_bin_q;
  logic [AXI_DW-1:0] rd_mux, rdata_q;

  assign wr_word   = {s_axi_awaddr_i[AXI_AW-1:2], 2'b00};
  assign ar_word   = {s_axi_araddr_i[AXI_AW-1:2], 2'b00};
  assign ar_off    = ar_word - AXI_AW'(ADDR_BIN_BASE);
  assign ar_is_bin = (ar_word >= AXI_AW'(ADDR_BIN_BASE)) &&
                     (ar_off[AXI_AW-1:2] < (AXI_AW-2)'(NUM_BINS));
  // writes win over reads in IDLE
  assign ar_take   = (state_q == IDLE) && !awready_q && !arready_q &&
                     !(s_axi_awvalid_i && s_axi_wvalid_i) && s_axi_arvalid_i;

  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      start_q   <= 1'b0;
      thresh_q  <= 8'd128;
    end else begin
      start_q <= 1'b0;                   // self clearing
      case (state_q)
        IDLE: begin
          if (awready_q) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b1;
            state_q   <= WRESP;
            case (wr_word)
              ADDR_CTRL:   start_q <= s_axi_wstrb_i[0] & s_axi_wdata_i[0];
              ADDR_THRESH: if (s_axi_wstrb_i[0]) thresh_q <= s_axi_wdata_i[PIX_W-1:0];
              default: ;                 // ignored, still OKAY
            endcase
          end else if (arready_q) begin
            arready_q <= 1'b0;
            state_q   <= RWAIT;
          end else if (s_axi_awvalid_i && s_axi_wvalid_i) begin
            awready_q <= 1'b1;
            wready_q  <= 1'b1;
          end else if (ar_take) begin
            arready_q <= 1'b1;
          end
        end
        WRESP: if (s_axi_bready_i) begin
          bvalid_q <= 1'b0;
          state_q  <= IDLE;
        end
        RWAIT: begin                     // bin port settles
          rvalid_q <= 1'b1;
          state_q  <= RRESP;
        end
        RRESP: if (s_axi_rready_i) begin
          rvalid_q <= 1'b0;
          state_q  <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ------------------------------
  always_comb begin
    rd_mux = '0;
    if (rd_is_bin_q) begin
      rd_mux = AXI_DW'(rd_count_i);
    end else begin
      case (rd_addr_q)
        ADDR_THRESH: rd_mux = AXI_DW'(thresh_q);
        ADDR_STATUS: rd_mux = AXI_DW'(done_i);
        default:     rd_mux = '0;        // CTRL and unmapped
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_take) begin
      rd_addr_q   <= ar_word;
      rd_is_bin_q <= ar_is_bin;
      rd_bin_q    <= ar_off[BIN_W+1:2];
    end
    if (state_q == RWAIT) begin
      rdata_q <= rd_mux;                 // held through RRESP
    end
  end

  assign s_axi_awready_o = awready_q;
  assign s_axi_wready_o  = wready_q;
  assign s_axi_bresp_o   = 2'b00;
  assign s_axi_bvalid_o  = bvalid_q;
  assign s_axi_arready_o = arready_q;
  assign s_axi_rdata_o   = rdata_q;
  assign s_axi_rresp_o   = 2'b00;
  assign s_axi_rvalid_o  = rvalid_q;
  assign thresh_o        = thresh_q;
  assign start_o         = start_q;
  assign rd_bin_o        = rd_bin_q;

endmodule

/* rtl/texture_top.sv */
`timescale 1ns/1ps

module texture_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [texture_pkg::PIX_W-1:0]    pixel_i,
  input  logic                             pixel_valid_i,
  input  logic [texture_pkg::AXI_AW-1:0]   s_axi_awaddr_i,
  input  logic                             s_axi_awvalid_i,
  output logic                             s_axi_awready_o,
  input  logic [texture_pkg::AXI_DW-1:0]   s_axi_wdata_i,
  input  logic [texture_pkg::AXI_DW/8-1:0] s_axi_wstrb_i,
  input  logic                             s_axi_wvalid_i,
  output logic                             s_axi_wready_o,
  output logic [1:0]                       s_axi_bresp_o,
  output logic                             s_axi_bvalid_o,
  input  logic                             s_axi_bready_i,
  input  logic [texture_pkg::AXI_AW-1:0]   s_axi_araddr_i,
  input  logic                             s_axi_arvalid_i,
  output logic                             s_axi_arready_o,
  output logic [texture_pkg::AXI_DW-1:0]   s_axi_rdata_o,
  output logic [1:0]                       s_axi_rresp_o,
  output logic                             s_axi_rvalid_o,
  input  logic                             s_axi_rready_i
);
  import texture_pkg::*;

  window_t          win;
  logic             win_valid;
  code_t            code;
  logic             code_valid;
  logic [PIX_W-1:0] thresh;
  logic             start;               // clears window and bins
  logic [BIN_W-1:0] rd_bin;
  logic [CNT_W-1:0] rd_count;
  logic             done;

  texture_regs u_regs (
    .clk             (clk),
    .rst_n           (rst_n),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .thresh_o        (thresh),
    .start_o         (start),
    .rd_bin_o        (rd_bin),
    .rd_count_i      (rd_count),
    .done_i          (done)
  );

  window_3x3 u_window (
    .clk           (clk),
    .rst_n         (rst_n),
    .clear_i       (start),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .win_o         (win),
    .win_valid_o   (win_valid)
  );

  lbp_code u_lbp (
    .clk          (clk),
    .rst_n        (rst_n),
    .win_i        (win),
    .win_valid_i  (win_valid),
    .thresh_i     (thresh),
    .code_o       (code),
    .code_valid_o (code_valid)
  );

  joint_histogram u_hist (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (start),
    .code_i       (code),
    .code_valid_i (code_valid),
    .rd_bin_i     (rd_bin),
    .rd_count_o   (rd_count),
    .done_o       (done)
  );

endmodule

/* rtl/window_3x3.sv */
`timescale 1ns/1ps

module window_3x3 (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clear_i,
  input  logic [texture_pkg::PIX_W-1:0] pixel_i,
  input  logic                          pixel_valid_i,
  output texture_pkg::window_t          win_o,
  output logic                          win_valid_o
);
  import texture_pkg::*;

  logic [PIX_W-1:0] line1_q [IMG_COLS];  // row above
  logic [PIX_W-1:0] line2_q [IMG_COLS];  // two rows above
  logic [PIX_W-1:0] win_q   [3][3];      // [row][col], row 0 is top
  logic [COL_W-1:0] col_q;
  logic [ROW_W-1:0] row_q;
  logic             win_valid_q;
  logic             win_last_q;
  logic             col_end;
  logic             row_end;

  assign col_end = (col_q == COL_W'(IMG_COLS - 1));
  assign row_end = (row_q == ROW_W'(IMG_ROWS - 1));

  // raster position and window strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_q <= 1'b0;
      win_last_q  <= 1'b0;
    end else if (clear_i) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_q <= 1'b0;
      win_last_q  <= 1'b0;
    end else begin
      win_valid_q <= pixel_valid_i && (col_q >= COL_W'(2)) && (row_q >= ROW_W'(2));
      win_last_q  <= pixel_valid_i && col_end && row_end;
      if (pixel_valid_i) begin
        col_q <= col_end ? '0 : col_q + 1'b1;
        if (col_end) begin
          row_q <= row_end ? '0 : row_q + 1'b1;
        end
      end
    end
  end

  // line buffers and shift window
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      line2_q[col_q] <= line1_q[col_q];
      line1_q[col_q] <= pixel_i;
      for (int r = 0; r < 3; r++) begin
        win_q[r][0] <= win_q[r][1];
        win_q[r][1] <= win_q[r][2];
      end
      win_q[0][2] <= line2_q[col_q];
      win_q[1][2] <= line1_q[col_q];
      win_q[2][2] <= pixel_i;            // newest column on the right
    end
  end

  always_comb begin
    win_o.center = win_q[1][1];
    win_o.nbr[0] = win_q[0][0];          // NW
    win_o.nbr[1] = win_q[0][1];          // N
    win_o.nbr[2] = win_q[0][2];          // NE
    win_o.nbr[3] = win_q[1][0];          // W
    win_o.nbr[4] = win_q[1][2];          // E
    win_o.nbr[5] = win_q[2][0];          // SW
    win_o.nbr[6] = win_q[2][1];          // S
    win_o.nbr[7] = win_q[2][2];          // SE
    win_o.last   = win_last_q;
  end

  assign win_valid_o = win_valid_q;

endmodule

/* tb/texture_checker.sv */
`timescale 1ns/1ps

module texture_checker (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [texture_pkg::PIX_W-1:0]    pixel_i,
  input  logic                             pixel_valid_i,
  input  logic [texture_pkg::AXI_AW-1:0]   awaddr_i,
  input  logic                             awvalid_i,
  input  logic                             awready_i,
  input  logic [texture_pkg::AXI_DW-1:0]   wdata_i,
  input  logic [texture_pkg::AXI_DW/8-1:0] wstrb_i,
  input  logic [1:0]                       bresp_i,
  input  logic                             bvalid_i,
  input  logic                             bready_i,
  input  logic [texture_pkg::AXI_AW-1:0]   araddr_i,
  input  logic                             arvalid_i,
  input  logic                             arready_i,
  input  logic [texture_pkg::AXI_DW-1:0]   rdata_i,
  input  logic [1:0]                       rresp_i,
  input  logic                             rvalid_i,
  input  logic                             rready_i,
  input  logic [8*12-1:0]                  test_name_i,
  input  int                               exp_total_i,
  output int                               error_count_o
);
  import texture_pkg::*;

  logic [PIX_W-1:0]  img [IMG_COLS*IMG_ROWS];
  int                pix_cnt;
  int                bin_sum;
  int                errors;
  logic [PIX_W-1:0]  thresh_m;
  logic [AXI_AW-1:0] wr_word;
  logic [AXI_AW-1:0] rd_addr;

  assign wr_word       = {awaddr_i[AXI_AW-1:2], 2'b00};
  assign error_count_o = errors;

  // ------------------------------
  // bin model: ci*9 + ni over the interior windows
  function automatic int model_bin(input int bin);
    int               cnt;
    int               ni;
    int               ci;
    logic [PIX_W-1:0] ctr;
    cnt = 0;
    for (int r = 1; r < IMG_ROWS - 1; r++) begin
      for (int c = 1; c < IMG_COLS - 1; c++) begin
        ctr = img[r * IMG_COLS + c];
        ni  = 0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            if ((dr != 0 || dc != 0) && img[(r + dr) * IMG_COLS + c + dc] >= ctr) begin
              ni++;
            end
          end
        end
        ci = (ctr >= thresh_m) ? 1 : 0;
        if (ci * 9 + ni == bin) begin
          cnt++;
        end
      end
    end
    return cnt;
  endfunction

  task automatic compare_value(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("[FAIL] %s: %s expected %0d actual %0d", test_name_i, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_read();
    int bin;
    bin = (int'(rd_addr) - int'(ADDR_BIN_BASE)) / 4;
    compare_value("read response", 0, int'(rresp_i));
    if (int'(rd_addr) >= int'(ADDR_BIN_BASE) && bin < NUM_BINS) begin
      bin_sum += int'(rdata_i);
      compare_value($sformatf("bin %0d", bin), model_bin(bin), int'(rdata_i));
      if (bin == NUM_BINS - 1) begin
        compare_value("sum of bins", exp_total_i, bin_sum);
      end
    end else if (rd_addr == ADDR_THRESH) begin
      compare_value("THRESH", int'(thresh_m), int'(rdata_i));
    end else if (rd_addr == ADDR_STATUS) begin
      if (pix_cnt < IMG_COLS * IMG_ROWS) begin   // frame not in yet
        compare_value("STATUS done", 0, int'(rdata_i));
      end
    end else begin
      compare_value($sformatf("register 0x%02h", rd_addr), 0, int'(rdata_i));
    end
  endtask

  // ------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      pix_cnt  = 0;
      bin_sum  = 0;
      errors   = 0;
      thresh_m = 8'd128;
    end else begin
      if (pixel_valid_i && pix_cnt < IMG_COLS * IMG_ROWS) begin
        img[pix_cnt] = pixel_i;
        pix_cnt++;
      end
      if (awvalid_i && awready_i) begin
        if (wr_word == ADDR_CTRL && wstrb_i[0] && wdata_i[0]) begin
          pix_cnt = 0;                           // new frame
          bin_sum = 0;
        end
        if (wr_word == ADDR_THRESH && wstrb_i[0]) begin
          thresh_m = wdata_i[PIX_W-1:0];
        end
      end
      if (bvalid_i && bready_i) begin
        compare_value("write response", 0, int'(bresp_i));
      end
      if (arvalid_i && arready_i) begin
        rd_addr = {araddr_i[AXI_AW-1:2], 2'b00};
      end
      if (rvalid_i && rready_i) begin
        check_read();
      end
    end
  end

endmodule

/* tb/texture_sva.sv */
`timescale 1ns/1ps

module texture_sva (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           bvalid_i,
  input logic                           bready_i,
  input logic                           rvalid_i,
  input logic                           rready_i,
  input logic [texture_pkg::AXI_DW-1:0] rdata_i,
  input logic                           start_i,
  input logic                           done_i
);

  logic started_q;                       // start seen since last done
  int   fail_count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started_q <= 1'b0;
    end else if (start_i) begin
      started_q <= 1'b1;
    end else if (done_i) begin
      started_q <= 1'b0;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin
      $error("rvalid or rdata changed before rready");
      fail_count++;
    end

  a_done_start: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done_i) |-> started_q)
    else begin
      $error("done rose with no start");
      fail_count++;
    end

endmodule

bind texture_top texture_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .bvalid_i (s_axi_bvalid_o),
  .bready_i (s_axi_bready_i),
  .rvalid_i (s_axi_rvalid_o),
  .rready_i (s_axi_rready_i),
  .rdata_i  (s_axi_rdata_o),
  .start_i  (start),
  .done_i   (done)
);

/* tb/texture_tb.sv */
`timescale 1ns/1ps

module texture_tb;
  import texture_pkg::*;

  typedef enum logic [2:0] {PAT_FLAT, PAT_RAMP, PAT_CHECKER, PAT_RANDOM, PAT_AGAIN} pattern_e;

  typedef struct packed {
    logic [8*12-1:0]  name;
    logic [PIX_W-1:0] thresh;
    pattern_e         pattern;
    logic [7:0]       total;                     // sum of all bins
  } test_row_t;

  logic                clk;
  logic                rst_n;
  logic [PIX_W-1:0]    pixel;
  logic                pixel_valid;
  logic [AXI_AW-1:0]   awaddr;
  logic                awvalid;
  logic                awready;
  logic [AXI_DW-1:0]   wdata;
  logic [AXI_DW/8-1:0] wstrb;
  logic                wvalid;
  logic                wready;
  logic [1:0]          bresp;
  logic                bvalid;
  logic                bready;
  logic [AXI_AW-1:0]   araddr;
  logic                arvalid;
  logic                arready;
  logic [AXI_DW-1:0]   rdata;
  logic [1:0]          rresp;
  logic                rvalid;
  logic                rready;
  logic [8*12-1:0]     cur_name;
  int                  cur_total;
  int                  check_errors;
  int                  passed;
  int                  failed;
  logic [15:0]         lfsr_q;
  logic [PIX_W-1:0]    frame [IMG_COLS*IMG_ROWS];
  test_row_t           tests [6];

  texture_top UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .pixel_i         (pixel),
    .pixel_valid_i   (pixel_valid),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wstrb_i   (wstrb),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready)
  );

  texture_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel),
    .pixel_valid_i (pixel_valid),
    .awaddr_i      (awaddr),
    .awvalid_i     (awvalid),
    .awready_i     (awready),
    .wdata_i       (wdata),
    .wstrb_i       (wstrb),
    .bresp_i       (bresp),
    .bvalid_i      (bvalid),
    .bready_i      (bready),
    .araddr_i      (araddr),
    .arvalid_i     (arvalid),
    .arready_i     (arready),
    .rdata_i       (rdata),
    .rresp_i       (rresp),
    .rvalid_i      (rvalid),
    .rready_i      (rready),
    .test_name_i   (cur_name),
    .exp_total_i   (cur_total),
    .error_count_o (check_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[6:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // checker mismatches plus assertion failures
  function automatic int error_total();
    return check_errors + UUT.u_sva.fail_count;
  endfunction

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("Test failed");
    $finish;
  endtask

  // ------------------------------
  task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data);
    int hold;
    int t;
    hold = int'(take_bits(3));                   // bready stall
    @(negedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    t = 0;
    while (!(awready && wready)) begin
      @(negedge clk);
      t++;
      if (t > 50) abort_run("the write address and data were never accepted");
    end
    @(negedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (hold) @(negedge clk);
    bready <= 1'b1;
    t = 0;
    while (!bvalid) begin
      @(negedge clk);
      t++;
      if (t > 50) abort_run("no write response came back");
    end
    @(negedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data);
    int hold;
    int t;
    hold = int'(take_bits(3));                   // rready stall
    @(negedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    t = 0;
    while (!arready) begin
      @(negedge clk);
      t++;
      if (t > 50) abort_run("the read address was never accepted");
    end
    @(negedge clk);
    arvalid <= 1'b0;
    repeat (hold) @(negedge clk);
    rready <= 1'b1;
    t = 0;
    while (!rvalid) begin
      @(negedge clk);
      t++;
      if (t > 50) abort_run("no read data came back");
    end
    data = rdata;
    @(negedge clk);
    rready <= 1'b0;
  endtask

  // ------------------------------
  task automatic make_frame(input pattern_e pat);
    int r;
    int c;
    for (int i = 0; i < IMG_COLS * IMG_ROWS; i++) begin
      r = i / IMG_COLS;
      c = i % IMG_COLS;
      case (pat)
        PAT_FLAT:    frame[i] = 8'd100;
        PAT_RAMP:    frame[i] = PIX_W'(r * 24 + c * 8);
        PAT_CHECKER: frame[i] = ((r + c) % 2 == 1) ? 8'd200 : 8'd40;
        PAT_RANDOM:  frame[i] = take_bits(8);
        default: ;                               // keep the previous frame
      endcase
    end
  endtask

  task automatic stream_frame();
    for (int i = 0; i < IMG_COLS * IMG_ROWS; i++) begin
      @(negedge clk);
      pixel       <= frame[i];
      pixel_valid <= 1'b1;
    end
    @(negedge clk);
    pixel_valid <= 1'b0;
  endtask

  task automatic run_test(input test_row_t row);
    int                errs_before;
    int                polls;
    logic [AXI_DW-1:0] rd;
    errs_before = error_total();
    cur_name    = row.name;
    cur_total   = int'(row.total);
    make_frame(row.pattern);
    axi_write(ADDR_THRESH, AXI_DW'(row.thresh));
    axi_read(ADDR_THRESH, rd);
    axi_write(ADDR_CTRL, 32'd1);
    axi_read(ADDR_STATUS, rd);                   // done must be clear now
    stream_frame();
    polls = 0;
    rd    = '0;
    while (!rd[0]) begin
      axi_read(ADDR_STATUS, rd);
      polls++;
      if (polls > 20) abort_run("the done flag never came up after the frame");
    end
    for (int k = 0; k < NUM_BINS; k++) begin
      axi_read(AXI_AW'(int'(ADDR_BIN_BASE) + 4 * k), rd);
    end
    axi_read(8'h0C, rd);                         // unmapped
    if (error_total() == errs_before) begin
      passed++;
      $display("test %s: ok", row.name);
    end else begin
      failed++;
      $display("test %s: %0d errors", row.name, error_total() - errs_before);
    end
  endtask

  // ------------------------------
  initial begin
    rst_n       = 1'b0;
    pixel       = '0;
    pixel_valid = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = 4'hF;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    cur_name    = '0;
    cur_total   = 0;
    passed      = 0;
    failed      = 0;
    lfsr_q      = 16'd66;
    tests[0] = '{"flat_low_thr", 8'd50,  PAT_FLAT,    8'd36};   // all in bin 17
    tests[1] = '{"flat_top_thr", 8'd200, PAT_FLAT,    8'd36};   // all in bin 8
    tests[2] = '{"ramp_split64", 8'd64,  PAT_RAMP,    8'd36};
    tests[3] = '{"checker_half", 8'd128, PAT_CHECKER, 8'd36};
    tests[4] = '{"random_frame", 8'd128, PAT_RANDOM,  8'd36};
    tests[5] = '{"repeat_frame", 8'd128, PAT_AGAIN,   8'd36};
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    foreach (tests[i]) begin
      run_test(tests[i]);
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             passed + failed, passed, failed, error_total());
    if (failed == 0 && error_total() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/texture_pkg.sv
rtl/window_3x3.sv
rtl/lbp_code.sv
rtl/joint_histogram.sv
rtl/texture_regs.sv
rtl/texture_top.sv
tb/texture_checker.sv
tb/texture_sva.sv
tb/texture_tb.sv
